/* build.f */
design/saturn_ops_pkg.sv
design/saturn_regs_pkg.sv
design/alu_sequencer.sv
design/alu_register_file.sv
design/alu_nibble_unit.sv
design/saturn_alu_top.sv
sim/tb_clock_gen.sv
sim/tb_saturn_alu.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_saturn_alu \
  --Mdir obj_dir -o sim_saturn_alu
./obj_dir/sim_saturn_alu | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sim/tb_saturn_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_alu;

  import saturn_ops_pkg::*;
  import saturn_regs_pkg::*;

  localparam int NUM_FIXED   = 18;
  localparam int NUM_RANDOM  = 8;
  localparam int NUM_TESTS   = NUM_FIXED + NUM_RANDOM;
  localparam int PERIOD_NS   = 40;
  localparam int WATCHDOG_NS = (NUM_TESTS * 50 + 40) * PERIOD_NS;
  localparam int DONE_LIMIT  = 60;

  typedef struct packed {
    alu_cmd_t   cmd;
    logic       poke_busy;
    reg_word_u  exp_word;
    nibble_t    exp_p;
    logic       exp_carry;
    logic [7:0] exp_cycles;
  } test_t;

  logic        clk;
  logic        reset;
  logic        start;
  alu_cmd_t    cmd_in;
  alu_reg_t    read_sel;
  reg_word_u   read_word;
  logic        carry;
  nibble_t     reg_p;
  logic        busy;
  logic        done;

  test_t       tests[$];
  string       test_names[$];
  logic [63:0] model_regs [4];
  nibble_t     model_p;
  logic        model_carry;
  logic [31:0] rng_state;
  int          error_count;
  int          check_total;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) u_clock_gen (
    .o_clk   (clk),
    .o_reset (reset)
  );

  saturn_alu_top uut (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_start     (start),
    .i_cmd       (cmd_in),
    .i_read_sel  (read_sel),
    .o_read_word (read_word),
    .o_carry     (carry),
    .o_reg_p     (reg_p),
    .o_busy      (busy),
    .o_done      (done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int field_len(input alu_cmd_t c);
    nib_idx_t span;
    span = c.field_last - c.field_first;
    return int'(span) + 1;
  endfunction

  function automatic nibble_t model_nib(input alu_reg_t sel, input nib_idx_t idx,
                                        input nibble_t imm);
    nibble_t nib;
    case (sel)
      REG_A, REG_B, REG_C, REG_D: nib = model_regs[sel[1:0]][{idx, 2'b00} +: 4];
      REG_P:                      nib = model_p;
      REG_IMM:                    nib = imm;
      default:                    nib = 4'h0;
    endcase
    return nib;
  endfunction

  // field as a number, field_first is the least significant nibble
  function automatic logic [63:0] gather(input alu_reg_t sel, input alu_cmd_t c);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < field_len(c); i++) begin
      v[i * 4 +: 4] = model_nib(sel, c.field_first + nib_idx_t'(i), c.imm);
    end
    return v;
  endfunction

  task automatic scatter(input alu_reg_t sel, input alu_cmd_t c, input logic [63:0] v);
    nib_idx_t idx;
    for (int i = 0; i < field_len(c); i++) begin
      idx = c.field_first + nib_idx_t'(i);
      // P keeps whatever the last field nibble wrote
      if (sel == REG_P) begin
        model_p = v[i * 4 +: 4];
      end else begin
        model_regs[sel[1:0]][{idx, 2'b00} +: 4] = v[i * 4 +: 4];
      end
    end
  endtask

  task automatic apply_model(input alu_cmd_t c);
    logic [63:0] s1;
    logic [63:0] s2;
    logic [63:0] mask;
    logic [64:0] wide;
    int          n;
    n    = field_len(c);
    s1   = gather(c.src1, c);
    s2   = gather(c.src2, c);
    mask = (n == 16) ? '1 : (64'd1 << (4 * n)) - 64'd1;
    case (c.op)
      OP_COPY:     wide = {1'b0, s1};
      OP_EXCH:     wide = {1'b0, s2};
      OP_ADD:      wide = {1'b0, s1} + {1'b0, s2};
      OP_DEC:      wide = {1'b0, s1} + {1'b0, mask};
      OP_2CMPL:    wide = {1'b0, (64'd0 - s1) & mask};
      OP_CLR_MASK: wide = {1'b0, s1 & ~s2};
      default:     wide = '0;
    endcase
    // carry out of the field sits just above its top nibble
    case (c.op)
      OP_ADD, OP_DEC: model_carry = wide[4 * n];
      OP_2CMPL:       model_carry = (s1 != 64'd0);
      OP_TEST_NEQ:    model_carry = (s1 != s2);
      default:        model_carry = model_carry;
    endcase
    if (c.op != OP_TEST_NEQ) begin
      scatter(c.dest, c, wide[63:0] & mask);
    end
    if (c.op == OP_EXCH) begin
      scatter(c.src2, c, s1);
    end
  endtask

  task automatic add_test(input string name, input alu_op_t op, input alu_reg_t dest,
                          input alu_reg_t src1, input alu_reg_t src2, input nib_idx_t first,
                          input nib_idx_t last, input nibble_t imm, input logic poke = 1'b0);
    test_t t;
    t.cmd.op          = op;
    t.cmd.dest        = dest;
    t.cmd.src1        = src1;
    t.cmd.src2        = src2;
    t.cmd.field_first = first;
    t.cmd.field_last  = last;
    t.cmd.imm         = imm;
    apply_model(t.cmd);
    t.poke_busy     = poke;
    t.exp_word.word = (dest == REG_P) ? {60'd0, model_p} : model_regs[dest[1:0]];
    t.exp_p         = model_p;
    t.exp_carry     = model_carry;
    t.exp_cycles    = 8'(3 * field_len(t.cmd) + 1);
    tests.push_back(t);
    test_names.push_back(name);
  endtask

  task automatic build_tests();
    logic [31:0] r;
    alu_op_t     op;
    alu_reg_t    s1;
    alu_reg_t    s2;
    add_test("copy_imm_a_mid", OP_COPY, REG_A, REG_IMM, REG_ZERO, 4'h3, 4'h7, 4'h5);
    add_test("copy_imm_b_wrap", OP_COPY, REG_B, REG_IMM, REG_ZERO, 4'hE, 4'h1, 4'h9);
    add_test("copy_imm_c_full", OP_COPY, REG_C, REG_IMM, REG_ZERO, 4'h0, 4'hF, 4'hA);
    add_test("copy_zero_c_part", OP_COPY, REG_C, REG_ZERO, REG_ZERO, 4'h4, 4'h9, 4'h0);
    add_test("copy_imm_p", OP_COPY, REG_P, REG_IMM, REG_ZERO, 4'h0, 4'h0, 4'h7);
    add_test("add_c_c_carry", OP_ADD, REG_C, REG_C, REG_C, 4'h0, 4'hF, 4'h0);
    add_test("add_a_b_wrap", OP_ADD, REG_D, REG_A, REG_B, 4'hC, 4'h3, 4'h0);
    add_test("dec_d_low", OP_DEC, REG_D, REG_D, REG_ZERO, 4'h0, 4'h3, 4'h0);
    add_test("dec_b_zero_field", OP_DEC, REG_B, REG_B, REG_ZERO, 4'h4, 4'h7, 4'h0);
    add_test("cmpl_a_low", OP_2CMPL, REG_A, REG_A, REG_ZERO, 4'h0, 4'h7, 4'h0);
    add_test("cmpl_zero_field", OP_2CMPL, REG_B, REG_ZERO, REG_ZERO, 4'hA, 4'hB, 4'h0);
    add_test("test_neq_a_c", OP_TEST_NEQ, REG_A, REG_A, REG_C, 4'h0, 4'hF, 4'h0);
    add_test("test_neq_c_c", OP_TEST_NEQ, REG_C, REG_C, REG_C, 4'h0, 4'hF, 4'h0);
    add_test("exch_a_c", OP_EXCH, REG_A, REG_A, REG_C, 4'h2, 4'h9, 4'h0);
    add_test("copy_c_readback", OP_COPY, REG_C, REG_C, REG_ZERO, 4'h0, 4'h0, 4'h0);
    add_test("clr_mask_d_imm", OP_CLR_MASK, REG_D, REG_D, REG_IMM, 4'h0, 4'hF, 4'h5);
    add_test("copy_a_b_busy_start", OP_COPY, REG_B, REG_A, REG_ZERO, 4'h5, 4'hC, 4'h0, 1'b1);
    add_test("add_p_imm", OP_ADD, REG_P, REG_P, REG_IMM, 4'h6, 4'h6, 4'hB);
    // register operands only, so no field nibble reads a P that it already wrote
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      case (r[2:0])
        3'd0, 3'd5: op = OP_COPY;
        3'd1, 3'd6: op = OP_ADD;
        3'd2, 3'd7: op = OP_DEC;
        3'd3:       op = OP_2CMPL;
        default:    op = OP_CLR_MASK;
      endcase
      s1 = r[5] ? REG_IMM : alu_reg_t'({1'b0, r[7:6]});
      s2 = r[8] ? REG_IMM : alu_reg_t'({1'b0, r[10:9]});
      add_test($sformatf("random_%0d", i), op, alu_reg_t'({1'b0, r[4:3]}), s1, s2,
               r[14:11], r[18:15], r[22:19]);
    end
  endtask

  task automatic check_word(input string name, input reg_word_u exp, input reg_word_u act);
    check_total++;
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp.word, act.word);
      error_count++;
    end
  endtask

  task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
    check_total++;
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_total++;
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    check_total++;
    if (act != exp) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      error_count++;
    end
  endtask

  task automatic read_back(input string name, input alu_reg_t sel, input reg_word_u exp);
    @(posedge clk);
    read_sel <= sel;
    @(negedge clk);
    check_word(name, exp, read_word);
  endtask

  // edges counts rising edges from the one that samples i_start
  task automatic run_test(input string name, input test_t t);
    int edges;
    edges = 0;
    @(posedge clk);
    start    <= 1'b1;
    cmd_in   <= t.cmd;
    read_sel <= t.cmd.dest;
    @(negedge clk);
    while (!done && edges < DONE_LIMIT) begin
      @(posedge clk);
      edges++;
      start <= t.poke_busy && (edges == 1);
      if (t.poke_busy && edges == 1) begin
        // would wipe the whole register if the core took it
        cmd_in.op          <= OP_ZERO;
        cmd_in.field_first <= 4'h0;
        cmd_in.field_last  <= 4'hF;
      end
      @(negedge clk);
    end
    if (!done) begin
      $display("test %s: no o_done within %0d cycles of i_start", name, DONE_LIMIT);
      error_count++;
    end
    check_cycles({name, " cycles"}, int'(t.exp_cycles), edges);
    // busy drops in the same cycle that done pulses
    check_flag({name, " busy"}, 1'b0, busy);
    check_word({name, " word"}, t.exp_word, read_word);
    check_nibble({name, " p"}, t.exp_p, reg_p);
    check_flag({name, " carry"}, t.exp_carry, carry);
  endtask

  initial begin
    int wait_cycles;
    start       = 1'b0;
    cmd_in      = '0;
    read_sel    = REG_A;
    error_count = 0;
    check_total = 0;
    model_regs  = '{default: 64'd0};
    model_p     = 4'h0;
    model_carry = 1'b0;
    rng_state   = 32'd4;
    build_tests();

    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    check_flag("reset busy", 1'b1, busy);
    check_flag("reset done", 1'b0, done);
    wait_cycles = 0;
    while (busy && wait_cycles < DONE_LIMIT) begin
      check_word("sweep read a", '0, read_word);
      @(negedge clk);
      wait_cycles++;
    end
    if (busy) begin
      $display("clear sweep still busy after %0d cycles", DONE_LIMIT);
      error_count++;
    end
    for (int r = 0; r < 4; r++) begin
      read_back($sformatf("reset reg %0d", r), alu_reg_t'(r), '0);
    end
    check_nibble("reset p", 4'h0, reg_p);
    check_flag("reset carry", 1'b0, carry);

    for (int i = 0; i < tests.size(); i++) begin
      run_test(test_names[i], tests[i]);
    end
    // nibbles outside every field must still match the model
    for (int r = 0; r < 4; r++) begin
      read_back($sformatf("final reg %0d", r), alu_reg_t'(r), model_regs[r]);
    end

    $display("checks: %0d, errors: %0d", check_total, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, errors so far: %0d", WATCHDOG_NS, error_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // reset drops on a rising edge, like every other driven input
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* design/saturn_alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module saturn_alu_top (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire                           i_start,
  input  wire saturn_ops_pkg::alu_cmd_t  i_cmd,
  input  wire saturn_ops_pkg::alu_reg_t  i_read_sel,
  output saturn_regs_pkg::reg_word_u     o_read_word,
  output logic                          o_carry,
  output saturn_ops_pkg::nibble_t        o_reg_p,
  output logic                          o_busy,
  output logic                          o_done
);

  import saturn_ops_pkg::*;

  alu_cmd_t  cmd;
  alu_step_t step;
  nibble_t   src1_nib;
  nibble_t   src2_nib;
  nibble_t   res1;
  nibble_t   res2;

  alu_sequencer u_sequencer (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_start (i_start),
    .i_cmd   (i_cmd),
    .o_cmd   (cmd),
    .o_step  (step),
    .o_busy  (o_busy),
    .o_done  (o_done)
  );

  alu_register_file u_register_file (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cmd       (cmd),
    .i_step      (step),
    .i_res1      (res1),
    .i_res2      (res2),
    .o_src1_nib  (src1_nib),
    .o_src2_nib  (src2_nib),
    .i_read_sel  (i_read_sel),
    .o_read_word (o_read_word),
    .o_reg_p     (o_reg_p)
  );

  alu_nibble_unit u_nibble_unit (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_cmd      (cmd),
    .i_step     (step),
    .i_src1_nib (src1_nib),
    .i_src2_nib (src2_nib),
    .o_res1     (res1),
    .o_res2     (res2),
    .o_carry    (o_carry)
  );

endmodule

`default_nettype wire

/* design/alu_nibble_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_nibble_unit (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire saturn_ops_pkg::alu_cmd_t  i_cmd,
  input  wire saturn_ops_pkg::alu_step_t i_step,
  input  wire saturn_ops_pkg::nibble_t   i_src1_nib,
  input  wire saturn_ops_pkg::nibble_t   i_src2_nib,
  output saturn_ops_pkg::nibble_t        o_res1,
  output saturn_ops_pkg::nibble_t        o_res2,
  output logic                          o_carry
);

  import saturn_ops_pkg::*;

  logic    chain_c;
  logic    nonzero;
  logic    cin;
  nibble_t calc_r1;
  nibble_t calc_r2;
  logic    calc_c;

  // negation is invert plus one, seeded into the lowest field nibble
  assign cin = i_step.first ? (i_cmd.op == OP_2CMPL) : chain_c;

  always_comb begin
    calc_r1 = i_src1_nib;
    calc_r2 = i_src2_nib;
    calc_c  = 1'b0;
    case (i_cmd.op)
      OP_ZERO: calc_r1 = '0;
      OP_EXCH: begin
        calc_r1 = i_src2_nib;
        calc_r2 = i_src1_nib;
      end
      OP_ADD:
        {calc_c, calc_r1} = {1'b0, i_src1_nib} + {1'b0, i_src2_nib} + 5'(cin);
      OP_DEC:
        {calc_c, calc_r1} = {1'b0, i_src1_nib} + 5'h0F + 5'(cin);
      OP_2CMPL:
        {calc_c, calc_r1} = {1'b0, ~i_src1_nib} + 5'(cin);
      // carry stays set once any nibble differed
      OP_TEST_NEQ: calc_c = (i_src1_nib != i_src2_nib) || cin;
      OP_CLR_MASK: calc_r1 = i_src1_nib & ~i_src2_nib;
      // COPY passes src1 straight through
      default: calc_r1 = i_src1_nib;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_step.calc) begin
      o_res1 <= calc_r1;
      o_res2 <= calc_r2;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      chain_c <= 1'b0;
      nonzero <= 1'b0;
      o_carry <= 1'b0;
    end else begin
      if (i_step.calc) begin
        chain_c <= calc_c;
        nonzero <= (i_src1_nib != '0) || (!i_step.first && nonzero);
      end
      if (i_step.save && i_step.last) begin
        case (i_cmd.op)
          OP_ADD, OP_DEC, OP_TEST_NEQ: o_carry <= chain_c;
          // negating a nonzero field borrows
          OP_2CMPL: o_carry <= nonzero;
          default: o_carry <= o_carry;
        endcase
      end
    end
  end

  // every calc comes straight out of a prep, never from the clear sweep
  a_calc_after_prep: assert property (@(posedge i_clk) disable iff (i_reset)
    i_step.calc |-> !i_step.init && $past(i_step.prep));

endmodule

`default_nettype wire

/* design/alu_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_register_file (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire saturn_ops_pkg::alu_cmd_t  i_cmd,
  input  wire saturn_ops_pkg::alu_step_t i_step,
  input  wire saturn_ops_pkg::nibble_t   i_res1,
  input  wire saturn_ops_pkg::nibble_t   i_res2,
  output saturn_ops_pkg::nibble_t        o_src1_nib,
  output saturn_ops_pkg::nibble_t        o_src2_nib,
  input  wire saturn_ops_pkg::alu_reg_t  i_read_sel,
  output saturn_regs_pkg::reg_word_u     o_read_word,
  output saturn_ops_pkg::nibble_t        o_reg_p
);

  import saturn_ops_pkg::*;
  import saturn_regs_pkg::*;

  // A, B, C, D in select order
  reg_word_u regs [4];
  nibble_t   reg_p;
  logic      wr_main;
  logic      wr_swap;

  function automatic logic is_word_reg(input alu_reg_t sel);
    return (sel == REG_A) || (sel == REG_B) || (sel == REG_C) || (sel == REG_D);
  endfunction

  function automatic nibble_t pick_nibble(input alu_reg_t sel);
    nibble_t nib;
    case (sel)
      REG_A, REG_B, REG_C, REG_D: nib = regs[sel[1:0]].nib[i_step.idx];
      REG_P:                      nib = reg_p;
      REG_IMM:                    nib = i_cmd.imm;
      default:                    nib = '0;
    endcase
    return nib;
  endfunction

  // operand nibbles are sampled once per nibble, at prep
  always_ff @(posedge i_clk) begin
    if (i_step.prep) begin
      o_src1_nib <= pick_nibble(i_cmd.src1);
      o_src2_nib <= pick_nibble(i_cmd.src2);
    end
  end

  // TEST_NEQ only touches CARRY
  assign wr_main = i_step.save && (i_cmd.op != OP_TEST_NEQ);
  // second half of an exchange lands in src2
  assign wr_swap = i_step.save && (i_cmd.op == OP_EXCH);

  always_ff @(posedge i_clk) begin
    if (i_step.init) begin
      for (int r = 0; r < 4; r++) begin
        regs[r].nib[i_step.idx] <= '0;
      end
    end
    if (wr_main && is_word_reg(i_cmd.dest)) begin
      regs[i_cmd.dest[1:0]].nib[i_step.idx] <= i_res1;
    end
    if (wr_swap && is_word_reg(i_cmd.src2)) begin
      regs[i_cmd.src2[1:0]].nib[i_step.idx] <= i_res2;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      reg_p <= '0;
    end else begin
      // P is a single nibble, so any field position replaces all of it
      if (wr_main && (i_cmd.dest == REG_P)) begin
        reg_p <= i_res1;
      end
      if (wr_swap && (i_cmd.src2 == REG_P)) begin
        reg_p <= i_res2;
      end
    end
  end

  // nibbles not yet reached by the clear sweep read as zero
  always_comb begin
    o_read_word = '0;
    if (!i_step.init) begin
      case (i_read_sel)
        REG_A, REG_B, REG_C, REG_D: o_read_word = regs[i_read_sel[1:0]];
        REG_P:                      o_read_word.word = WORD_W'(reg_p);
        default:                    o_read_word = '0;
      endcase
    end
  end

  assign o_reg_p = reg_p;

  // the decoder must never hand a command that saves into IMM or ZERO
  a_save_target: assert property (@(posedge i_clk) disable iff (i_reset)
    (wr_main |-> (is_word_reg(i_cmd.dest) || i_cmd.dest == REG_P)) and
    (wr_swap |-> (is_word_reg(i_cmd.src2) || i_cmd.src2 == REG_P)));

endmodule

`default_nettype wire

/* design/alu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer (
  input  wire                         i_clk,
  input  wire                         i_reset,
  input  wire                         i_start,
  input  wire saturn_ops_pkg::alu_cmd_t i_cmd,
  output saturn_ops_pkg::alu_cmd_t    o_cmd,
  output saturn_ops_pkg::alu_step_t   o_step,
  output logic                        o_busy,
  output logic                        o_done
);

  import saturn_ops_pkg::*;

  alu_cmd_t cmd_q;
  nib_idx_t idx_q;
  logic     init_q;
  logic     prep_q;
  logic     calc_q;
  logic     save_q;
  logic     done_q;
  logic     start_ok;
  logic     at_last;

  assign o_busy   = init_q | prep_q | calc_q | save_q;
  assign start_ok = i_start && !o_busy;
  assign at_last  = (idx_q == cmd_q.field_last);

  // command is held for the whole field
  always_ff @(posedge i_clk) begin
    if (start_ok) begin
      cmd_q <= i_cmd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      init_q <= 1'b1;
      prep_q <= 1'b0;
      calc_q <= 1'b0;
      save_q <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (init_q) begin
        // clear sweep walks all 16 nibble positions once
        idx_q <= idx_q + 4'd1;
        if (idx_q == 4'hF) begin
          init_q <= 1'b0;
        end
      end else if (start_ok) begin
        idx_q  <= i_cmd.field_first;
        prep_q <= 1'b1;
      end else if (prep_q) begin
        prep_q <= 1'b0;
        calc_q <= 1'b1;
      end else if (calc_q) begin
        calc_q <= 1'b0;
        save_q <= 1'b1;
      end else if (save_q) begin
        save_q <= 1'b0;
        if (at_last) begin
          done_q <= 1'b1;
        end else begin
          // field wraps 15 -> 0 through the 4-bit index
          idx_q  <= idx_q + 4'd1;
          prep_q <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_step.init  = init_q;
    o_step.prep  = prep_q;
    o_step.calc  = calc_q;
    o_step.save  = save_q;
    o_step.first = (idx_q == cmd_q.field_first);
    o_step.last  = at_last;
    o_step.idx   = idx_q;
  end

  assign o_cmd  = cmd_q;
  assign o_done = done_q;

  a_one_phase: assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({init_q, prep_q, calc_q, save_q}));

endmodule

`default_nettype wire

/* design/saturn_regs_pkg.sv */
`default_nettype none

package saturn_regs_pkg;

  localparam int NIBBLES = 16;
  localparam int WORD_W  = 64;

  // a working register, written nibble by nibble and read as one word
  typedef union packed {
    logic [WORD_W-1:0]                        word;
    saturn_ops_pkg::nibble_t [NIBBLES-1:0]    nib;
  } reg_word_u;

endpackage

`default_nettype wire

/* design/saturn_ops_pkg.sv */
`default_nettype none

package saturn_ops_pkg;

  // operations kept in this core
  typedef enum logic [3:0] {
    OP_ZERO     = 4'd0,
    OP_COPY     = 4'd1,
    OP_EXCH     = 4'd2,
    OP_ADD      = 4'd3,
    OP_DEC      = 4'd4,
    OP_2CMPL    = 4'd5,
    OP_TEST_NEQ = 4'd6,
    OP_CLR_MASK = 4'd7
  } alu_op_t;

  // operand and destination selects
  // A..D share bit 2 low so bits [1:0] index the word registers
  typedef enum logic [2:0] {
    REG_A    = 3'd0,
    REG_B    = 3'd1,
    REG_C    = 3'd2,
    REG_D    = 3'd3,
    REG_P    = 3'd4,
    REG_IMM  = 3'd5,
    REG_ZERO = 3'd6
  } alu_reg_t;

  typedef logic [3:0] nibble_t;
  typedef logic [3:0] nib_idx_t;

  typedef struct packed {
    alu_op_t  op;
    alu_reg_t dest;
    alu_reg_t src1;
    alu_reg_t src2;
    nib_idx_t field_first;
    nib_idx_t field_last;
    nibble_t  imm;
  } alu_cmd_t;

  // one-hot phase strobes plus the nibble being worked on
  typedef struct packed {
    logic     init;
    logic     prep;
    logic     calc;
    logic     save;
    logic     first;
    logic     last;
    nib_idx_t idx;
  } alu_step_t;

endpackage

`default_nettype wire
